// File: cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 4

// Physical address split into tag, index and offset
`define CACHE_ADDR_BITS 15
`define CACHE_TAG_BITS 9
`define CACHE_INDEX_BITS 2
`define CACHE_OFFSET_BITS 4

// One line is 16 bytes
`define CACHE_LINE_BITS 128

`endif

// File: cache_pkg.sv
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

    typedef logic [`CACHE_TAG_BITS-1:0]   cache_tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] cache_index_t;
    typedef logic [1:0]                   cache_way_t;
    typedef logic [`CACHE_WAYS-1:0]       cache_ways_t;
    typedef logic [1:0]                   cache_age_t;

    // Field view of a physical address
    typedef struct packed {
        cache_tag_t                     tag;
        cache_index_t                   index;
        logic [`CACHE_OFFSET_BITS-1:0]  offset;
    } cache_addr_fields_t;

    // Lookup reads the fields, write-back sends the raw word
    typedef union packed {
        logic [`CACHE_ADDR_BITS-1:0] raw;
        cache_addr_fields_t          f;
    } cache_addr_u;

endpackage

`default_nettype wire

// File: cache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_tag_store import cache_pkg::*; (
    input  logic                                      clk,
    input  cache_index_t                              index,
    input  cache_tag_t                                tag_in,
    input  logic                                      tag_we,
    input  cache_way_t                                tag_way,
    output cache_ways_t                               tag_match,
    output logic [`CACHE_WAYS*`CACHE_TAG_BITS-1:0]    victim_tag_all
);

    cache_tag_t tags_q [`CACHE_SETS][`CACHE_WAYS];

    // Only a fill writes a tag
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags_q[index][tag_way] <= tag_in;
        end
    end

    // Raw compare of all ways before the valid bits are applied
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            tag_match[w] = (tags_q[index][w] == tag_in);
        end
    end

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            victim_tag_all[w*`CACHE_TAG_BITS +: `CACHE_TAG_BITS] = tags_q[index][w];
        end
    end

endmodule

`default_nettype wire

// File: cache_meta_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_meta_store import cache_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  cache_index_t                    index,
    input  logic                            upd,
    input  cache_way_t                      upd_way,
    input  logic                            set_valid,
    input  logic                            set_dirty,
    input  logic                            clr_dirty,
    output cache_ways_t                     valid_bits,
    output cache_ways_t                     dirty_bits,
    output cache_age_t [`CACHE_WAYS-1:0]    ages
);

    cache_ways_t                    valid_q [`CACHE_SETS];
    cache_ways_t                    dirty_q [`CACHE_SETS];
    cache_age_t [`CACHE_WAYS-1:0]   age_q   [`CACHE_SETS];
    cache_age_t                     used_age;

    // An invalid way counts as the oldest, so that filling an empty
    // set builds up a full 0..3 age order
    assign used_age = valid_q[index][upd_way] ? age_q[index][upd_way] : '1;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                age_q[s]   <= '0;
            end
        end else if (upd) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (cache_way_t'(w) == upd_way) begin
                    age_q[index][w] <= '0;
                end else if (age_q[index][w] < used_age) begin
                    age_q[index][w] <= age_q[index][w] + 1'b1;
                end
            end
            if (set_valid) begin
                valid_q[index][upd_way] <= 1'b1;
            end
            if (set_dirty) begin
                dirty_q[index][upd_way] <= 1'b1;
            end else if (clr_dirty) begin
                dirty_q[index][upd_way] <= 1'b0;
            end
        end
    end

    assign valid_bits = valid_q[index];
    assign dirty_bits = dirty_q[index];
    assign ages       = age_q[index];

endmodule

`default_nettype wire

// File: cache_way_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_way_select import cache_pkg::*; (
    input  cache_ways_t                     tag_match,
    input  cache_ways_t                     valid_bits,
    input  cache_ways_t                     dirty_bits,
    input  cache_age_t [`CACHE_WAYS-1:0]    ages,
    input  logic                            req_valid,
    input  logic                            is_fill,
    input  logic                            mshr_full,
    output cache_way_t                      way,
    output logic                            hit,
    output logic                            miss,
    output logic                            stall,
    output logic                            victim_dirty
);

    cache_ways_t hits_v;
    cache_way_t  hit_way;
    cache_way_t  victim_way;
    logic        any_hit;

    assign hits_v  = tag_match & valid_bits;
    assign any_hit = |hits_v;

    always_comb begin
        hit_way = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (hits_v[w]) begin
                hit_way = cache_way_t'(w);
            end
        end
    end

    // Oldest way first, then the lowest invalid way takes priority
    always_comb begin
        victim_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (ages[w] == '1) begin
                victim_way = cache_way_t'(w);
            end
        end
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_bits[w]) begin
                victim_way = cache_way_t'(w);
            end
        end
    end

    assign way          = is_fill ? victim_way : hit_way;
    assign victim_dirty = valid_bits[victim_way] & dirty_bits[victim_way];

    // Fills never hit and never stall
    assign hit   = req_valid & ~is_fill & any_hit;
    assign miss  = req_valid & ~is_fill & ~any_hit;
    assign stall = miss & mshr_full;

endmodule

`default_nettype wire

// File: cache_stage1.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_stage1 import cache_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid_in,
    input  logic                          rd,
    input  logic                          wr,
    input  logic                          fill,
    input  cache_addr_u                   paddr,
    input  logic [`CACHE_LINE_BITS-1:0]   data_in,
    input  logic [`CACHE_LINE_BITS-1:0]   mask_in,
    input  logic                          mshr_full,
    output logic                          hit,
    output logic                          miss,
    output logic                          stall,
    output logic                          s2_valid,
    output logic                          s2_write,
    output logic                          s2_fill,
    output logic                          s2_hit,
    output cache_index_t                  s2_index,
    output cache_way_t                    s2_way,
    output logic [`CACHE_LINE_BITS-1:0]   s2_data,
    output logic [`CACHE_LINE_BITS-1:0]   s2_mask,
    output logic                          s2_evict,
    output cache_tag_t                    s2_victim_tag
);

    cache_index_t                               index;
    cache_tag_t                                 tag;
    cache_ways_t                                tag_match;
    cache_ways_t                                valid_bits;
    cache_ways_t                                dirty_bits;
    cache_age_t [`CACHE_WAYS-1:0]               ages;
    logic [`CACHE_WAYS*`CACHE_TAG_BITS-1:0]     victim_tag_all;
    cache_way_t                                 way;
    cache_tag_t                                 victim_tag;
    logic                                       victim_dirty;
    logic                                       accept;

    assign index  = paddr.f.index;
    assign tag    = paddr.f.tag;
    assign accept = valid_in & ~stall;

    // Stored tag of the chosen way, used as the write-back address
    assign victim_tag = victim_tag_all[way*`CACHE_TAG_BITS +: `CACHE_TAG_BITS];

    cache_tag_store u_tag_store (
        .clk            (clk),
        .index          (index),
        .tag_in         (tag),
        .tag_we         (accept & fill),
        .tag_way        (way),
        .tag_match      (tag_match),
        .victim_tag_all (victim_tag_all)
    );

    cache_meta_store u_meta_store (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .upd        (accept & (hit | fill)),
        .upd_way    (way),
        .set_valid  (fill),
        .set_dirty  (wr & hit),
        .clr_dirty  (fill),
        .valid_bits (valid_bits),
        .dirty_bits (dirty_bits),
        .ages       (ages)
    );

    cache_way_select u_way_select (
        .tag_match    (tag_match),
        .valid_bits   (valid_bits),
        .dirty_bits   (dirty_bits),
        .ages         (ages),
        .req_valid    (valid_in & (rd | wr | fill)),
        .is_fill      (fill),
        .mshr_full    (mshr_full),
        .way          (way),
        .hit          (hit),
        .miss         (miss),
        .stall        (stall),
        .victim_dirty (victim_dirty)
    );

    // Stage register with its flags qualified by the accept every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
            s2_write <= 1'b0;
            s2_fill  <= 1'b0;
            s2_hit   <= 1'b0;
            s2_evict <= 1'b0;
        end else begin
            s2_valid <= accept;
            s2_write <= accept & wr;
            s2_fill  <= accept & fill;
            s2_hit   <= accept & hit;
            s2_evict <= accept & fill & victim_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s2_index      <= index;
            s2_way        <= way;
            s2_data       <= data_in;
            s2_mask       <= mask_in;
            s2_victim_tag <= victim_tag;
        end
    end

endmodule

`default_nettype wire

// File: cache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_data_store import cache_pkg::*; (
    input  logic                          clk,
    input  logic                          s2_valid,
    input  logic                          s2_write,
    input  logic                          s2_fill,
    input  logic                          s2_hit,
    input  cache_index_t                  s2_index,
    input  cache_way_t                    s2_way,
    input  logic [`CACHE_LINE_BITS-1:0]   s2_data,
    input  logic [`CACHE_LINE_BITS-1:0]   s2_mask,
    input  logic                          s2_evict,
    input  cache_tag_t                    s2_victim_tag,
    output logic                          valid_out,
    output logic                          hit_out,
    output logic [`CACHE_LINE_BITS-1:0]   cache_line,
    output logic                          ex_wb,
    output logic [`CACHE_ADDR_BITS-1:0]   ext_addr
);

    logic [`CACHE_LINE_BITS-1:0] lines_q [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_LINE_BITS-1:0] rd_line;
    cache_addr_u                 wb_addr;

    // Old contents that also serve as the evicted data on a dirty fill
    assign rd_line = lines_q[s2_index][s2_way];

    always_ff @(posedge clk) begin
        if (s2_valid && s2_fill) begin
            lines_q[s2_index][s2_way] <= s2_data;
        end else if (s2_valid && s2_write && s2_hit) begin
            lines_q[s2_index][s2_way] <= (rd_line & ~s2_mask) | (s2_data & s2_mask);
        end
    end

    // Line address of the victim
    always_comb begin
        wb_addr.f.tag    = s2_victim_tag;
        wb_addr.f.index  = s2_index;
        wb_addr.f.offset = '0;
    end

    assign valid_out  = s2_valid;
    assign hit_out    = s2_hit;
    assign ex_wb      = s2_evict;
    assign cache_line = rd_line;
    assign ext_addr   = wb_addr.raw;

endmodule

`default_nettype wire

// File: cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_top import cache_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid_in,
    input  logic                          rd,
    input  logic                          wr,
    input  logic                          fill,
    input  logic [`CACHE_ADDR_BITS-1:0]   paddr,
    input  logic [`CACHE_LINE_BITS-1:0]   data_in,
    input  logic [`CACHE_LINE_BITS-1:0]   mask_in,
    input  logic                          mshr_full,
    output logic                          hit,
    output logic                          miss,
    output logic                          stall,
    output logic                          valid_out,
    output logic                          hit_out,
    output logic [`CACHE_LINE_BITS-1:0]   cache_line,
    output logic                          ex_wb,
    output logic [`CACHE_ADDR_BITS-1:0]   ext_addr
);

    logic                         s2_valid;
    logic                         s2_write;
    logic                         s2_fill;
    logic                         s2_hit;
    cache_index_t                 s2_index;
    cache_way_t                   s2_way;
    logic [`CACHE_LINE_BITS-1:0]  s2_data;
    logic [`CACHE_LINE_BITS-1:0]  s2_mask;
    logic                         s2_evict;
    cache_tag_t                   s2_victim_tag;

    cache_stage1 u_stage1 (
        .clk           (clk),
        .rst           (rst),
        .valid_in      (valid_in),
        .rd            (rd),
        .wr            (wr),
        .fill          (fill),
        .paddr         (paddr),
        .data_in       (data_in),
        .mask_in       (mask_in),
        .mshr_full     (mshr_full),
        .hit           (hit),
        .miss          (miss),
        .stall         (stall),
        .s2_valid      (s2_valid),
        .s2_write      (s2_write),
        .s2_fill       (s2_fill),
        .s2_hit        (s2_hit),
        .s2_index      (s2_index),
        .s2_way        (s2_way),
        .s2_data       (s2_data),
        .s2_mask       (s2_mask),
        .s2_evict      (s2_evict),
        .s2_victim_tag (s2_victim_tag)
    );

    cache_data_store u_data_store (
        .clk           (clk),
        .s2_valid      (s2_valid),
        .s2_write      (s2_write),
        .s2_fill       (s2_fill),
        .s2_hit        (s2_hit),
        .s2_index      (s2_index),
        .s2_way        (s2_way),
        .s2_data       (s2_data),
        .s2_mask       (s2_mask),
        .s2_evict      (s2_evict),
        .s2_victim_tag (s2_victim_tag),
        .valid_out     (valid_out),
        .hit_out       (hit_out),
        .cache_line    (cache_line),
        .ex_wb         (ex_wb),
        .ext_addr      (ext_addr)
    );

endmodule

`default_nettype wire

// File: tb_cache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_assert (
    input logic clk,
    input logic rst,
    input logic valid_in,
    input logic miss,
    input logic stall,
    input logic valid_out,
    input logic ex_wb
);

    stall_needs_miss: assert property (@(posedge clk) disable iff (rst) stall |-> miss)
        else $error("stall raised without a miss");

    // A stalled request is not accepted, so nothing leaves stage 2 next cycle
    no_output_after_stall: assert property (
        @(posedge clk) disable iff (rst) (valid_in && stall) |=> !valid_out
    ) else $error("valid_out raised in the cycle after a stalled request");

    wb_needs_valid: assert property (@(posedge clk) disable iff (rst) ex_wb |-> valid_out)
        else $error("ex_wb raised without valid_out");

endmodule

bind cache_top tb_cache_assert u_protocol_check (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (valid_in),
    .miss      (miss),
    .stall     (stall),
    .valid_out (valid_out),
    .ex_wb     (ex_wb)
);

`default_nettype wire

// File: tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module tb_cache;

    localparam int OP_RD = 0;
    localparam int OP_WR = 1;
    localparam int OP_FILL = 2;
    localparam int PERIOD_NS = 40;
    localparam int RESET_CYCLES = 16;
    // About two cycles per access over all six tests
    localparam int TEST_CYCLES = 60;
    localparam int MARGIN_CYCLES = 200;

    logic                          clk;
    logic                          rst;
    logic                          valid_in;
    logic                          rd;
    logic                          wr;
    logic                          fill;
    logic [`CACHE_ADDR_BITS-1:0]   paddr;
    logic [`CACHE_LINE_BITS-1:0]   data_in;
    logic [`CACHE_LINE_BITS-1:0]   mask_in;
    logic                          mshr_full;
    logic                          hit;
    logic                          miss;
    logic                          stall;
    logic                          valid_out;
    logic                          hit_out;
    logic [`CACHE_LINE_BITS-1:0]   cache_line;
    logic                          ex_wb;
    logic [`CACHE_ADDR_BITS-1:0]   ext_addr;

    // Reference state of the cache
    logic [`CACHE_TAG_BITS-1:0]    m_tag   [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]        m_valid [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0]        m_dirty [`CACHE_SETS];
    logic [1:0]                    m_age   [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_LINE_BITS-1:0]   m_line  [`CACHE_SETS][`CACHE_WAYS];

    // Expected responses with one slot per pipeline stage
    int                            p_op      [2];
    logic [`CACHE_INDEX_BITS-1:0]  p_idx     [2];
    logic [`CACHE_TAG_BITS-1:0]    p_tag     [2];
    logic                          p_hit     [2];
    logic                          p_miss    [2];
    logic [1:0]                    p_way     [2];
    logic                          p_line_ok [2];
    logic [`CACHE_LINE_BITS-1:0]   p_line    [2];
    logic                          p_wb      [2];
    logic [`CACHE_ADDR_BITS-1:0]   p_ext     [2];

    integer seed = 12;
    int     errors = 0;
    int     test_errs = 0;
    int     tests = 0;
    int     checks = 0;
    int     wb_seen = 0;

    cache_top DUT (
        .clk        (clk),
        .rst        (rst),
        .valid_in   (valid_in),
        .rd         (rd),
        .wr         (wr),
        .fill       (fill),
        .paddr      (paddr),
        .data_in    (data_in),
        .mask_in    (mask_in),
        .mshr_full  (mshr_full),
        .hit        (hit),
        .miss       (miss),
        .stall      (stall),
        .valid_out  (valid_out),
        .hit_out    (hit_out),
        .cache_line (cache_line),
        .ex_wb      (ex_wb),
        .ext_addr   (ext_addr)
    );

    initial clk = 1'b0;
    always #(PERIOD_NS / 2) clk = ~clk;

    function automatic logic [`CACHE_LINE_BITS-1:0] rand_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic logic [`CACHE_ADDR_BITS-1:0] make_addr(
        input logic [`CACHE_TAG_BITS-1:0] tag,
        input logic [`CACHE_INDEX_BITS-1:0] idx
    );
        return {tag, idx, 4'($random(seed))};
    endfunction

    task automatic expect_eq(input string name, input string what,
                             input logic [127:0] exp, input logic [127:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAIL %s: %s expected %h actual %h", name, what, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic predict(input int slot, input int op,
                           input logic [`CACHE_ADDR_BITS-1:0] addr);
        logic [`CACHE_INDEX_BITS-1:0] idx;
        logic [`CACHE_TAG_BITS-1:0]   tg;
        logic                         found;
        logic [1:0]                   hway;
        logic [1:0]                   vway;
        idx = addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
        tg = addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
        found = 1'b0;
        hway = 2'd0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                found = 1'b1;
                hway = 2'(w);
            end
        end
        // Oldest way unless some way is still empty
        vway = 2'd0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_age[idx][w] == 2'd3) begin
                vway = 2'(w);
            end
        end
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!m_valid[idx][w]) begin
                vway = 2'(w);
            end
        end
        p_op[slot] = op;
        p_idx[slot] = idx;
        p_tag[slot] = tg;
        p_hit[slot] = (op != OP_FILL) && found;
        p_miss[slot] = (op != OP_FILL) && !found;
        p_way[slot] = (op == OP_FILL) ? vway : hway;
        p_line_ok[slot] = p_hit[slot] || (op == OP_FILL && m_valid[idx][vway]);
        p_line[slot] = m_line[idx][p_way[slot]];
        p_wb[slot] = (op == OP_FILL) && m_valid[idx][vway] && m_dirty[idx][vway];
        p_ext[slot] = {m_tag[idx][vway], idx, 4'h0};
    endtask

    task automatic commit(input int slot, input logic [127:0] data, input logic [127:0] mask);
        logic [`CACHE_INDEX_BITS-1:0] idx;
        logic [1:0]                   way;
        logic [1:0]                   used;
        idx = p_idx[slot];
        way = p_way[slot];
        if (p_op[slot] == OP_FILL || p_hit[slot]) begin
            // An empty way counts as the oldest one
            used = m_valid[idx][way] ? m_age[idx][way] : 2'd3;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (2'(w) == way) begin
                    m_age[idx][w] = 2'd0;
                end else if (m_age[idx][w] < used) begin
                    m_age[idx][w] = m_age[idx][w] + 2'd1;
                end
            end
        end
        if (p_op[slot] == OP_FILL) begin
            m_tag[idx][way] = p_tag[slot];
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
            m_line[idx][way] = data;
        end else if (p_op[slot] == OP_WR && p_hit[slot]) begin
            m_dirty[idx][way] = 1'b1;
            m_line[idx][way] = (m_line[idx][way] & ~mask) | (data & mask);
        end
    endtask

    task automatic send_request(input int op, input logic [`CACHE_ADDR_BITS-1:0] addr,
                                input logic [127:0] data, input logic [127:0] mask,
                                input logic full);
        @(posedge clk);
        valid_in  <= 1'b1;
        rd        <= (op == OP_RD);
        wr        <= (op == OP_WR);
        fill      <= (op == OP_FILL);
        paddr     <= addr;
        data_in   <= data;
        mask_in   <= mask;
        mshr_full <= full;
    endtask

    task automatic go_idle();
        @(posedge clk);
        valid_in <= 1'b0;
        rd       <= 1'b0;
        wr       <= 1'b0;
        fill     <= 1'b0;
    endtask

    task automatic check_lookup(input string name, input int slot, input logic full);
        expect_eq(name, "hit", 128'(p_hit[slot]), 128'(hit));
        expect_eq(name, "miss", 128'(p_miss[slot]), 128'(miss));
        expect_eq(name, "stall", 128'(p_miss[slot] & full), 128'(stall));
    endtask

    task automatic check_result(input string name, input int slot);
        expect_eq(name, "valid_out", 128'(1'b1), 128'(valid_out));
        expect_eq(name, "hit_out", 128'(p_hit[slot]), 128'(hit_out));
        expect_eq(name, "ex_wb", 128'(p_wb[slot]), 128'(ex_wb));
        if (p_line_ok[slot]) begin
            expect_eq(name, "cache_line", p_line[slot], cache_line);
        end
        if (p_wb[slot]) begin
            expect_eq(name, "ext_addr", 128'(p_ext[slot]), 128'(ext_addr));
        end
        if (ex_wb === 1'b1) begin
            wb_seen++;
        end
    endtask

    // One request through both stages with nothing else in flight
    task automatic access(input string name, input int op,
                          input logic [`CACHE_ADDR_BITS-1:0] addr,
                          input logic [127:0] data, input logic [127:0] mask,
                          input logic full);
        predict(0, op, addr);
        send_request(op, addr, data, mask, full);
        @(negedge clk);
        check_lookup(name, 0, full);
        commit(0, data, mask);
        go_idle();
        @(negedge clk);
        check_result(name, 0);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_errs == 0) begin
            $display("%-18s ok", name);
        end else begin
            $display("%-18s %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic reset_miss();
        for (int i = 0; i < 4; i++) begin
            access("reset_miss", OP_RD, 15'($random(seed)), '0, '0, 1'b0);
        end
        finish_test("reset_miss");
    endtask

    task automatic fill_then_read();
        logic [127:0] d;
        d = rand_line();
        access("fill_then_read", OP_FILL, make_addr(9'h0b3, 2'd1), d, '0, 1'b0);
        access("fill_then_read", OP_RD, make_addr(9'h0b3, 2'd1), '0, '0, 1'b0);
        expect_eq("fill_then_read", "filled line", d, cache_line);
        finish_test("fill_then_read");
    endtask

    task automatic write_merge();
        logic [127:0] d;
        logic [127:0] m;
        logic [127:0] old;
        d = rand_line();
        m = rand_line();
        access("write_merge", OP_WR, make_addr(9'h0b3, 2'd1), d, m, 1'b0);
        old = p_line[0];
        access("write_merge", OP_RD, make_addr(9'h0b3, 2'd1), '0, '0, 1'b0);
        expect_eq("write_merge", "merged line", (old & ~m) | (d & m), cache_line);
        finish_test("write_merge");
    endtask

    task automatic lru_eviction();
        logic [8:0] tg [6];
        tg = '{9'h021, 9'h0c4, 9'h137, 9'h1a9, 9'h05e, 9'h0f2};
        wb_seen = 0;
        for (int i = 0; i < 4; i++) begin
            access("lru_eviction", OP_FILL, make_addr(tg[i], 2'd2), rand_line(), '0, 1'b0);
        end
        access("lru_eviction", OP_WR, make_addr(tg[0], 2'd2), rand_line(), rand_line(), 1'b0);
        access("lru_eviction", OP_RD, make_addr(tg[2], 2'd2), '0, '0, 1'b0);
        // Second line is now the oldest and clean
        access("lru_eviction", OP_FILL, make_addr(tg[4], 2'd2), rand_line(), '0, 1'b0);
        access("lru_eviction", OP_RD, make_addr(tg[3], 2'd2), '0, '0, 1'b0);
        // First line is now the oldest and dirty
        access("lru_eviction", OP_FILL, make_addr(tg[5], 2'd2), rand_line(), '0, 1'b0);
        expect_eq("lru_eviction", "write-back address", 128'({tg[0], 2'd2, 4'h0}),
                  128'(ext_addr));
        access("lru_eviction", OP_RD, make_addr(tg[0], 2'd2), '0, '0, 1'b0);
        access("lru_eviction", OP_RD, make_addr(tg[4], 2'd2), '0, '0, 1'b0);
        expect_eq("lru_eviction", "dirty evictions", 128'(1), 128'(wb_seen));
        finish_test("lru_eviction");
    endtask

    task automatic mshr_backpressure();
        logic [`CACHE_ADDR_BITS-1:0] a_miss;
        a_miss = make_addr(9'h155, 2'd3);
        access("mshr_backpressure", OP_FILL, make_addr(9'h04d, 2'd3), rand_line(), '0, 1'b0);
        predict(0, OP_RD, a_miss);
        send_request(OP_RD, a_miss, '0, '0, 1'b1);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_lookup("mshr_backpressure", 0, 1'b1);
            expect_eq("mshr_backpressure", "valid_out under stall", '0, 128'(valid_out));
        end
        // Request stays on the inputs while the MSHR drains
        @(posedge clk);
        mshr_full <= 1'b0;
        @(negedge clk);
        check_lookup("mshr_backpressure", 0, 1'b0);
        commit(0, '0, '0);
        go_idle();
        @(negedge clk);
        check_result("mshr_backpressure", 0);
        access("mshr_backpressure", OP_RD, make_addr(9'h04d, 2'd3), '0, '0, 1'b1);
        finish_test("mshr_backpressure");
    endtask

    task automatic back_to_back();
        logic [`CACHE_ADDR_BITS-1:0] a;
        logic [127:0]                d;
        logic [127:0]                m;
        a = make_addr(9'h0b3, 2'd1);
        d = rand_line();
        m = rand_line();
        predict(0, OP_WR, a);
        send_request(OP_WR, a, d, m, 1'b0);
        @(negedge clk);
        check_lookup("back_to_back", 0, 1'b0);
        commit(0, d, m);
        predict(1, OP_RD, a);
        send_request(OP_RD, a, '0, '0, 1'b0);
        @(negedge clk);
        check_lookup("back_to_back", 1, 1'b0);
        check_result("back_to_back", 0);
        commit(1, '0, '0);
        go_idle();
        @(negedge clk);
        check_result("back_to_back", 1);
        finish_test("back_to_back");
    endtask

    initial begin
        rst       = 1'b1;
        valid_in  = 1'b0;
        rd        = 1'b0;
        wr        = 1'b0;
        fill      = 1'b0;
        paddr     = '0;
        data_in   = '0;
        mask_in   = '0;
        mshr_full = 1'b0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_valid[s] = '0;
            m_dirty[s] = '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_age[s][w] = 2'd0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        reset_miss();
        fill_then_read();
        write_merge();
        lru_eviction();
        mshr_backpressure();
        back_to_back();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * PERIOD_NS);
        $display("Watchdog expired before the tests completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
cache_pkg.sv
cache_tag_store.sv
cache_meta_store.sv
cache_way_select.sv
cache_stage1.sv
cache_data_store.sv
cache_top.sv
tb_cache_assert.sv
tb_cache.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_cache \
    && ./obj_dir/Vtb_cache | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }
